// ==== design/dcache_pkg.sv ====
package dcache_pkg;

	// address and data geometry
	localparam int addr_w     = 32;
	localparam int word_w     = 32;
	localparam int byte_lanes = word_w / 8;

	// 8 sets of 4 words, two ways
	localparam int offset_w   = 2;
	localparam int index_w    = 3;
	localparam int tag_w      = addr_w - index_w - offset_w - 2;
	localparam int num_sets   = 1 << index_w;
	localparam int line_words = 1 << offset_w;

	typedef logic [addr_w-1:0]     addr_t;
	typedef logic [word_w-1:0]     word_t;
	typedef logic [byte_lanes-1:0] strb_t;
	typedef logic [tag_w-1:0]      tag_t;
	typedef logic [index_w-1:0]    index_t;
	typedef logic [offset_w-1:0]   offset_t;

	// miss and refill controller
	typedef enum logic [2:0]
	{
		ctrl_idle,
		// one cycle after every accepted access
		ctrl_respond,
		// dirty victim goes out first
		ctrl_wb_addr,
		ctrl_wb_data,
		// then the missing line comes in
		ctrl_rd_addr,
		ctrl_rd_data,
		ctrl_fill_done
	} ctrl_state_t;

endpackage

// ==== design/dcache_tag_store.sv ====
`timescale 1ns/100ps

module dcache_tag_store import dcache_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  index_t lookup_index,
	input  tag_t   lookup_tag,
	input  logic   fill,
	input  logic   fill_way,
	input  index_t fill_index,
	input  tag_t   fill_tag,
	input  logic   mark_dirty,
	input  logic   clean,
	input  logic   touch,
	input  logic   touch_way,
	output logic   hit0,
	output logic   hit1,
	output logic   victim_way,
	output logic   victim_dirty,
	output tag_t   victim_tag
);

	// per-way tag array
	tag_t tags [2][num_sets];

	// per-way status bits, one per set
	logic [num_sets-1:0] valid [2];
	logic [num_sets-1:0] dirty [2];

	// lru points at the way to replace next
	logic [num_sets-1:0] lru;

	// a stale tag in an invalid entry must not hit
	assign hit0 = valid[0][lookup_index] && (tags[0][lookup_index] == lookup_tag);
	assign hit1 = valid[1][lookup_index] && (tags[1][lookup_index] == lookup_tag);

	assign victim_way   = lru[lookup_index];
	assign victim_dirty = valid[victim_way][lookup_index] && dirty[victim_way][lookup_index];
	assign victim_tag   = tags[victim_way][lookup_index];

	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			tags[fill_way][fill_index] <= fill_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid[0] <= '0;
			valid[1] <= '0;
			dirty[0] <= '0;
			dirty[1] <= '0;
			lru      <= '0;
		end
		else
		begin
			// a refilled line starts clean
			if (fill)
			begin
				valid[fill_way][fill_index] <= 1'b1;
				dirty[fill_way][fill_index] <= 1'b0;
			end
			// end of write-back
			if (clean)
			begin
				dirty[fill_way][fill_index] <= 1'b0;
			end
			if (mark_dirty)
			begin
				dirty[touch_way][lookup_index] <= 1'b1;
			end
			// the other way becomes least recently used
			if (touch)
			begin
				lru[lookup_index] <= ~touch_way;
			end
		end
	end

	// a refill never installs a tag already present in the other way
	assert property (@(posedge clk) disable iff (!rst_n) !(hit0 && hit1));

endmodule

// ==== design/dcache_data_store.sv ====
`timescale 1ns/100ps

module dcache_data_store import dcache_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    we,
	input  logic    wr_way,
	input  index_t  wr_index,
	input  offset_t wr_offset,
	input  strb_t   wr_strb,
	input  word_t   wr_data,
	input  logic    rd_way,
	input  index_t  rd_index,
	input  offset_t rd_offset,
	output word_t   rd_data
);

	// two ways, words addressed by {index, offset}
	word_t mem [2][num_sets*line_words];

	logic [index_w+offset_w-1:0] wr_addr;
	logic [index_w+offset_w-1:0] rd_addr;

	assign wr_addr = {wr_index, wr_offset};
	assign rd_addr = {rd_index, rd_offset};

	// byte-masked write
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			for (int b = 0; b < byte_lanes; b++)
			begin
				if (wr_strb[b])
				begin
					mem[wr_way][wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	// result stage, word of the selected way one cycle after the address
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_data <= '0;
		end
		else
		begin
			rd_data <= mem[rd_way][rd_addr];
		end
	end

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    cpu_re,
	input  logic    cpu_we,
	input  addr_t   cpu_addr,
	input  strb_t   cpu_strb,
	input  word_t   cpu_wdata,
	input  logic    hit0,
	input  logic    hit1,
	input  logic    victim_way,
	input  logic    victim_dirty,
	input  tag_t    victim_tag,
	input  word_t   line_data,
	input  logic    awready,
	input  logic    wready,
	input  logic    arready,
	input  logic    rvalid,
	input  word_t   rdata,
	output logic    stall,
	output logic    fill,
	output logic    fill_way,
	output index_t  fill_index,
	output tag_t    fill_tag,
	output logic    mark_dirty,
	output logic    clean,
	output logic    touch,
	output logic    touch_way,
	output logic    we,
	output logic    wr_way,
	output index_t  wr_index,
	output offset_t wr_offset,
	output strb_t   wr_strb,
	output word_t   wr_data,
	output logic    rd_way,
	output index_t  rd_index,
	output offset_t rd_offset,
	output logic    awvalid,
	output addr_t   awaddr,
	output logic    wvalid,
	output word_t   wdata,
	output logic    wlast,
	output logic    arvalid,
	output addr_t   araddr,
	output logic    rready
);

	ctrl_state_t state;
	offset_t     beat;

	// line being replaced, captured when the miss is seen
	logic   miss_way;
	index_t miss_index;
	tag_t   miss_tag;
	tag_t   wb_tag;

	tag_t    cpu_tag;
	index_t  cpu_index;
	offset_t cpu_offset;
	logic    access;
	logic    hit;
	logic    w_hs;

	assign cpu_tag    = cpu_addr[addr_w-1 -: tag_w];
	assign cpu_index  = cpu_addr[addr_w-tag_w-1 -: index_w];
	assign cpu_offset = cpu_addr[addr_w-tag_w-index_w-1 -: offset_w];

	assign access = cpu_re | cpu_we;
	assign hit    = hit0 | hit1;
	assign w_hs   = wvalid & wready;

	assign stall = (state != ctrl_idle) || (access && !hit);

	// tag store strobes
	assign touch      = (state == ctrl_idle) && access && hit;
	assign touch_way  = hit1;
	assign mark_dirty = touch && cpu_we;
	assign fill       = (state == ctrl_fill_done);
	assign fill_way   = miss_way;
	assign fill_index = miss_index;
	assign fill_tag   = miss_tag;
	assign clean      = (state == ctrl_wb_data) && w_hs && wlast;

	// line-aligned burst addresses
	assign awaddr = {wb_tag, miss_index, {(addr_w-tag_w-index_w){1'b0}}};
	assign araddr = {miss_tag, miss_index, {(addr_w-tag_w-index_w){1'b0}}};

	// refill beats or cpu write hits
	always_comb
	begin
		if (state == ctrl_rd_data)
		begin
			we        = rvalid & rready;
			wr_way    = miss_way;
			wr_index  = miss_index;
			wr_offset = beat;
			wr_strb   = '1;
			wr_data   = rdata;
		end
		else
		begin
			we        = mark_dirty;
			wr_way    = hit1;
			wr_index  = cpu_index;
			wr_offset = cpu_offset;
			wr_strb   = cpu_strb;
			wr_data   = cpu_wdata;
		end
	end

	// look ahead one word on a W handshake so the next beat is ready
	always_comb
	begin
		if (state == ctrl_idle)
		begin
			rd_way    = hit1;
			rd_index  = cpu_index;
			rd_offset = cpu_offset;
		end
		else
		begin
			rd_way    = miss_way;
			rd_index  = miss_index;
			rd_offset = beat + offset_t'(w_hs);
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == ctrl_idle) && access && !hit)
		begin
			miss_way   <= victim_way;
			miss_index <= cpu_index;
			miss_tag   <= cpu_tag;
			wb_tag     <= victim_tag;
		end
	end

	// held until wready
	always_ff @(posedge clk)
	begin
		if ((state == ctrl_wb_data) && !wvalid)
		begin
			wdata <= line_data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= ctrl_idle;
			beat    <= '0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			wlast   <= 1'b0;
			arvalid <= 1'b0;
			rready  <= 1'b0;
		end
		else
		begin
			case (state)
				ctrl_idle:
				begin
					if (access && hit)
					begin
						state <= ctrl_respond;
					end
					else if (access)
					begin
						beat <= '0;
						if (victim_dirty)
						begin
							awvalid <= 1'b1;
							state   <= ctrl_wb_addr;
						end
						else
						begin
							arvalid <= 1'b1;
							state   <= ctrl_rd_addr;
						end
					end
				end
				ctrl_respond:
				begin
					state <= ctrl_idle;
				end
				ctrl_wb_addr:
				begin
					if (awready)
					begin
						awvalid <= 1'b0;
						state   <= ctrl_wb_data;
					end
				end
				ctrl_wb_data:
				begin
					if (!wvalid)
					begin
						wvalid <= 1'b1;
						wlast  <= (beat == offset_t'(line_words - 1));
					end
					else if (wready)
					begin
						wvalid <= 1'b0;
						wlast  <= 1'b0;
						beat   <= beat + 1'b1;
						// write-back done, go fetch the missing line
						if (wlast)
						begin
							beat    <= '0;
							arvalid <= 1'b1;
							state   <= ctrl_rd_addr;
						end
					end
				end
				ctrl_rd_addr:
				begin
					if (arready)
					begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= ctrl_rd_data;
					end
				end
				ctrl_rd_data:
				begin
					if (rvalid)
					begin
						beat <= beat + 1'b1;
						if (beat == offset_t'(line_words - 1))
						begin
							rready <= 1'b0;
							state  <= ctrl_fill_done;
						end
					end
				end
				ctrl_fill_done:
				begin
					state <= ctrl_idle;
				end
				default:
				begin
					state <= ctrl_idle;
				end
			endcase
		end
	end

	// last beat flag only travels with valid write data
	assert property (@(posedge clk) disable iff (!rst_n) wlast |-> wvalid);

	// write-back and refill address phases never overlap
	assert property (@(posedge clk) disable iff (!rst_n) !(arvalid && awvalid));

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  cpu_re,
	input  logic  cpu_we,
	input  addr_t cpu_addr,
	input  strb_t cpu_strb,
	input  word_t cpu_wdata,
	output word_t cpu_rdata,
	output logic  stall,
	output logic  awvalid,
	input  logic  awready,
	output addr_t awaddr,
	output logic  wvalid,
	input  logic  wready,
	output word_t wdata,
	output logic  wlast,
	output logic  arvalid,
	input  logic  arready,
	output addr_t araddr,
	input  logic  rvalid,
	output logic  rready,
	input  word_t rdata
);

	tag_t    lookup_tag;
	index_t  lookup_index;
	logic    hit0;
	logic    hit1;
	logic    victim_way;
	logic    victim_dirty;
	tag_t    victim_tag;
	logic    fill;
	logic    fill_way;
	index_t  fill_index;
	tag_t    fill_tag;
	logic    mark_dirty;
	logic    clean;
	logic    touch;
	logic    touch_way;
	logic    we;
	logic    wr_way;
	index_t  wr_index;
	offset_t wr_offset;
	strb_t   wr_strb;
	word_t   wr_data;
	logic    rd_way;
	index_t  rd_index;
	offset_t rd_offset;
	word_t   line_data;

	// read word capture
	logic  rd_pending;
	word_t rd_hold;

	assign lookup_tag   = cpu_addr[addr_w-1 -: tag_w];
	assign lookup_index = cpu_addr[addr_w-tag_w-1 -: index_w];

	// store output moves during bursts, so keep the last read word
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_pending <= 1'b0;
		end
		else
		begin
			rd_pending <= cpu_re & ~cpu_we & ~stall;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_pending)
		begin
			rd_hold <= line_data;
		end
	end

	assign cpu_rdata = rd_pending ? line_data : rd_hold;

	dcache_tag_store i_tag_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.lookup_index (lookup_index),
		.lookup_tag   (lookup_tag),
		.fill         (fill),
		.fill_way     (fill_way),
		.fill_index   (fill_index),
		.fill_tag     (fill_tag),
		.mark_dirty   (mark_dirty),
		.clean        (clean),
		.touch        (touch),
		.touch_way    (touch_way),
		.hit0         (hit0),
		.hit1         (hit1),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	dcache_ctrl i_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_re       (cpu_re),
		.cpu_we       (cpu_we),
		.cpu_addr     (cpu_addr),
		.cpu_strb     (cpu_strb),
		.cpu_wdata    (cpu_wdata),
		.hit0         (hit0),
		.hit1         (hit1),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.line_data    (line_data),
		.awready      (awready),
		.wready       (wready),
		.arready      (arready),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.stall        (stall),
		.fill         (fill),
		.fill_way     (fill_way),
		.fill_index   (fill_index),
		.fill_tag     (fill_tag),
		.mark_dirty   (mark_dirty),
		.clean        (clean),
		.touch        (touch),
		.touch_way    (touch_way),
		.we           (we),
		.wr_way       (wr_way),
		.wr_index     (wr_index),
		.wr_offset    (wr_offset),
		.wr_strb      (wr_strb),
		.wr_data      (wr_data),
		.rd_way       (rd_way),
		.rd_index     (rd_index),
		.rd_offset    (rd_offset),
		.awvalid      (awvalid),
		.awaddr       (awaddr),
		.wvalid       (wvalid),
		.wdata        (wdata),
		.wlast        (wlast),
		.arvalid      (arvalid),
		.araddr       (araddr),
		.rready       (rready)
	);

	dcache_data_store i_data_store (
		.clk       (clk),
		.rst_n     (rst_n),
		.we        (we),
		.wr_way    (wr_way),
		.wr_index  (wr_index),
		.wr_offset (wr_offset),
		.wr_strb   (wr_strb),
		.wr_data   (wr_data),
		.rd_way    (rd_way),
		.rd_index  (rd_index),
		.rd_offset (rd_offset),
		.rd_data   (line_data)
	);

endmodule

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model import dcache_pkg::*;
#(
	parameter int unsigned seed = 32'h1
)
(
	input  logic  clk,
	input  logic  awvalid,
	output logic  awready,
	input  addr_t awaddr,
	input  logic  wvalid,
	output logic  wready,
	input  word_t wdata,
	input  logic  wlast,
	input  logic  arvalid,
	output logic  arready,
	input  addr_t araddr,
	output logic  rvalid,
	input  logic  rready,
	output word_t rdata,
	output int    read_bursts,
	output int    write_bursts,
	output int    last_beats,
	output int    model_errors
);

	// 16 KiB of modeled memory, word addressed
	localparam int mem_words = 4096;

	word_t shadow [mem_words];

	function automatic int word_index(input addr_t addr);
		return int'(addr[13:2]);
	endfunction

	task automatic check_range(input addr_t addr);
		if (addr[addr_w-1:14] != '0)
		begin
			$display("memory model: burst address %h lies outside the modeled memory", addr);
			model_errors++;
		end
	endtask

	// AR handshake, then four R beats with random gaps
	task automatic serve_reads();
		addr_t base;
		int    b;
		forever
		begin
			@(negedge clk);
			if (arvalid)
			begin
				repeat ($urandom_range(3)) @(negedge clk);
				base    = araddr;
				arready = 1'b1;
				@(negedge clk);
				arready = 1'b0;
				read_bursts++;
				check_range(base);
				for (b = 0; b < line_words; b++)
				begin
					repeat ($urandom_range(3)) @(negedge clk);
					while (!rready)
					begin
						@(negedge clk);
					end
					rvalid = 1'b1;
					rdata  = shadow[word_index(base) + b];
					@(negedge clk);
					rvalid = 1'b0;
				end
			end
		end
	endtask

	// AW handshake, then W beats until wlast; the burst lands in shadow at the end
	task automatic serve_writes();
		addr_t base;
		int    beats;
		int    b;
		logic  last;
		word_t burst [line_words];
		forever
		begin
			@(negedge clk);
			if (awvalid)
			begin
				repeat ($urandom_range(3)) @(negedge clk);
				base    = awaddr;
				awready = 1'b1;
				@(negedge clk);
				awready = 1'b0;
				check_range(base);
				beats = 0;
				last  = 1'b0;
				while (!last)
				begin
					while (!wvalid)
					begin
						@(negedge clk);
					end
					repeat ($urandom_range(3)) @(negedge clk);
					wready = 1'b1;
					if (beats < line_words)
					begin
						burst[beats] = wdata;
					end
					else
					begin
						$display("memory model: write burst runs past one cache line");
						model_errors++;
					end
					last = wlast;
					beats++;
					@(negedge clk);
					wready = 1'b0;
				end
				for (b = 0; b < beats && b < line_words; b++)
				begin
					shadow[word_index(base) + b] = burst[b];
				end
				last_beats = beats;
				write_bursts++;
			end
		end
	endtask

	initial
	begin
		awready      = 1'b0;
		wready       = 1'b0;
		arready      = 1'b0;
		rvalid       = 1'b0;
		rdata        = '0;
		read_bursts  = 0;
		write_bursts = 0;
		last_beats   = 0;
		model_errors = 0;
		// initial content is the word address xor a marker
		for (int i = 0; i < mem_words; i++)
		begin
			shadow[i] = word_t'(i) ^ 32'h5a5a0000;
		end
		void'($urandom(seed));
		fork
			serve_reads();
			serve_writes();
		join
	end

endmodule

// ==== bench/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb import dcache_pkg::*;
();

	localparam int          num_tests       = 17;
	localparam int          cycles_per_test = 200;
	localparam int          reset_cycles    = 2;
	localparam int          mem_words       = 4096;
	localparam int unsigned rand_seed       = 32'h537dce6a;

	logic  clk;
	logic  rst_n;
	logic  cpu_re;
	logic  cpu_we;
	addr_t cpu_addr;
	strb_t cpu_strb;
	word_t cpu_wdata;
	word_t cpu_rdata;
	logic  stall;
	logic  awvalid;
	logic  awready;
	addr_t awaddr;
	logic  wvalid;
	logic  wready;
	word_t wdata;
	logic  wlast;
	logic  arvalid;
	logic  arready;
	addr_t araddr;
	logic  rvalid;
	logic  rready;
	word_t rdata;

	int read_bursts;
	int write_bursts;
	int last_beats;
	int model_errors;

	// stimulus table
	string test_name [num_tests];
	logic  is_write [num_tests];
	addr_t test_addr [num_tests];
	strb_t test_strb [num_tests];
	word_t test_wdata [num_tests];
	word_t exp_rdata [num_tests];
	int    exp_reads [num_tests];
	int    exp_writes [num_tests];
	addr_t wb_line [num_tests];
	int    n_tests;

	// what the CPU should see as memory
	word_t ref_mem [mem_words];

	// word of the most recent accepted read
	word_t last_read;
	logic  have_read;

	int mismatches;
	int other_errors;
	int tests_run;

	always #50 clk = ~clk;

	dcache_top i_dcache_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_re    (cpu_re),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_strb  (cpu_strb),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.stall     (stall),
		.awvalid   (awvalid),
		.awready   (awready),
		.awaddr    (awaddr),
		.wvalid    (wvalid),
		.wready    (wready),
		.wdata     (wdata),
		.wlast     (wlast),
		.arvalid   (arvalid),
		.arready   (arready),
		.araddr    (araddr),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata)
	);

	axi_mem_model #(.seed(rand_seed)) i_axi_mem_model (
		.clk          (clk),
		.awvalid      (awvalid),
		.awready      (awready),
		.awaddr       (awaddr),
		.wvalid       (wvalid),
		.wready       (wready),
		.wdata        (wdata),
		.wlast        (wlast),
		.arvalid      (arvalid),
		.arready      (arready),
		.araddr       (araddr),
		.rvalid       (rvalid),
		.rready       (rready),
		.rdata        (rdata),
		.read_bursts  (read_bursts),
		.write_bursts (write_bursts),
		.last_beats   (last_beats),
		.model_errors (model_errors)
	);

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
		input strb_t strb);
		word_t mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	task automatic init_ref();
		for (int i = 0; i < mem_words; i++)
		begin
			ref_mem[i] = word_t'(i) ^ 32'h5a5a0000;
		end
	endtask

	// line 0 marks an entry without a write-back
	task automatic add_test(input string name, input logic wr, input addr_t addr,
		input strb_t strb, input word_t data, input int reads, input int writes,
		input addr_t line);
		test_name[n_tests]  = name;
		is_write[n_tests]   = wr;
		test_addr[n_tests]  = addr;
		test_strb[n_tests]  = strb;
		test_wdata[n_tests] = data;
		exp_rdata[n_tests]  = '0;
		exp_reads[n_tests]  = reads;
		exp_writes[n_tests] = writes;
		wb_line[n_tests]    = line;
		n_tests++;
	endtask

	task automatic build_table();
		int idx;
		//          name                    wr  addr     strb  wdata     ar aw wb line
		add_test("cold_read",            0, 32'h014, 4'hf, 32'h0,        1, 0, 32'h0);
		add_test("same_line_read",       0, 32'h01c, 4'hf, 32'h0,        0, 0, 32'h0);
		add_test("write_hit_partial",    1, 32'h018, 4'h5, 32'ha1b2c3d4, 0, 0, 32'h0);
		add_test("read_merged",          0, 32'h018, 4'hf, 32'h0,        0, 0, 32'h0);
		// three tags in set 2
		add_test("lru_fill_a",           0, 32'h020, 4'hf, 32'h0,        1, 0, 32'h0);
		add_test("lru_fill_b",           0, 32'h0a0, 4'hf, 32'h0,        1, 0, 32'h0);
		add_test("lru_touch_a",          0, 32'h024, 4'hf, 32'h0,        0, 0, 32'h0);
		add_test("lru_evict_b",          0, 32'h120, 4'hf, 32'h0,        1, 0, 32'h0);
		add_test("lru_reread_b",         0, 32'h0a4, 4'hf, 32'h0,        1, 0, 32'h0);
		// both ways of set 1 dirty then evicted
		add_test("fill_second_way",      0, 32'h094, 4'hf, 32'h0,        1, 0, 32'h0);
		add_test("write_second_way",     1, 32'h090, 4'hf, 32'h11223344, 0, 0, 32'h0);
		add_test("dirty_evict",          0, 32'h114, 4'hf, 32'h0,        1, 1, 32'h010);
		add_test("dirty_evict_again",    0, 32'h214, 4'hf, 32'h0,        1, 1, 32'h090);
		add_test("reload_written",       0, 32'h018, 4'hf, 32'h0,        1, 0, 32'h0);
		add_test("reload_written_again", 0, 32'h090, 4'hf, 32'h0,        1, 0, 32'h0);
		// write miss allocates first
		add_test("write_miss",           1, 32'h038, 4'hc, 32'hdeadbeef, 1, 0, 32'h0);
		add_test("read_write_miss",      0, 32'h038, 4'hf, 32'h0,        0, 0, 32'h0);
		init_ref();
		for (int i = 0; i < n_tests; i++)
		begin
			idx = int'(test_addr[i][13:2]);
			if (is_write[i])
			begin
				ref_mem[idx] = merge_bytes(ref_mem[idx], test_wdata[i], test_strb[i]);
			end
			else
			begin
				exp_rdata[i] = ref_mem[idx];
			end
		end
		// replayed again while the table runs
		init_ref();
	endtask

	task automatic run_test(input int i);
		int reads_before;
		int writes_before;
		int idx;
		reads_before  = read_bursts;
		writes_before = write_bursts;
		cpu_re    = !is_write[i];
		cpu_we    = is_write[i];
		cpu_addr  = test_addr[i];
		cpu_strb  = test_strb[i];
		cpu_wdata = test_wdata[i];
		@(posedge clk);
		while (stall)
		begin
			@(posedge clk);
		end
		// previous read word survives any bursts in between
		if (have_read)
		begin
			check_value({test_name[i], " held rdata"}, last_read, cpu_rdata);
		end
		// accepted on that edge
		@(negedge clk);
		cpu_re = 1'b0;
		cpu_we = 1'b0;
		idx    = int'(test_addr[i][13:2]);
		if (is_write[i])
		begin
			ref_mem[idx] = merge_bytes(ref_mem[idx], test_wdata[i], test_strb[i]);
		end
		else
		begin
			check_value(test_name[i], exp_rdata[i], cpu_rdata);
			last_read = exp_rdata[i];
			have_read = 1'b1;
		end
		check_value({test_name[i], " read bursts"}, word_t'(exp_reads[i]),
			word_t'(read_bursts - reads_before));
		check_value({test_name[i], " write bursts"}, word_t'(exp_writes[i]),
			word_t'(write_bursts - writes_before));
		if (wb_line[i] != '0)
		begin
			check_value({test_name[i], " beats"}, word_t'(line_words), word_t'(last_beats));
			idx = int'(wb_line[i][13:2]);
			for (int b = 0; b < line_words; b++)
			begin
				check_value($sformatf("%s wb word %0d", test_name[i], b), ref_mem[idx + b],
					i_axi_mem_model.shadow[idx + b]);
			end
		end
		tests_run++;
	endtask

	task automatic close_run(input logic timed_out);
		$display("%0d tests run, %0d mismatches, %0d other errors", tests_run, mismatches,
			other_errors + model_errors);
		if (!timed_out && mismatches == 0 && other_errors + model_errors == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	initial
	begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		cpu_re       = 1'b0;
		cpu_we       = 1'b0;
		cpu_addr     = '0;
		cpu_strb     = '0;
		cpu_wdata    = '0;
		last_read    = '0;
		have_read    = 1'b0;
		mismatches   = 0;
		other_errors = 0;
		tests_run    = 0;
		n_tests      = 0;
		build_table();
		if (n_tests != num_tests)
		begin
			$display("the stimulus table holds %0d entries instead of %0d", n_tests, num_tests);
			other_errors++;
		end
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// idle bus and no stall straight out of reset
		check_value("reset stall", 32'h0, word_t'(stall));
		check_value("reset awvalid", 32'h0, word_t'(awvalid));
		check_value("reset wvalid", 32'h0, word_t'(wvalid));
		check_value("reset wlast", 32'h0, word_t'(wlast));
		check_value("reset arvalid", 32'h0, word_t'(arvalid));
		check_value("reset rready", 32'h0, word_t'(rready));
		for (int t = 0; t < n_tests; t++)
		begin
			run_test(t);
		end
		close_run(1'b0);
	end

	// watchdog
	initial
	begin
		repeat (reset_cycles + cycles_per_test * num_tests) @(posedge clk);
		$display("timeout: the cache did not get through the stimulus table in time");
		close_run(1'b1);
	end

endmodule

// ==== filelist.f ====
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/axi_mem_model.sv
bench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/dcache_tag_store.sv
      - design/dcache_data_store.sv
      - design/dcache_ctrl.sv
      - design/dcache_top.sv
  - target: simulation
    files:
      - bench/axi_mem_model.sv
      - bench/dcache_tb.sv
